// ==== lsu_macros.svh ====
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// byte address width
`define LSU_ADDR_W      32

// one pipeline word
`define LSU_DATA_W      64

// direct-mapped index, 64 lines
`define LSU_INDEX_W     6

// 32-byte lines
`define LSU_LINE_WORDS  4

// event counter width
`define LSU_CNT_W       64

`endif

// ==== lsu_pkg.sv ====
`include "lsu_macros.svh"

package lsu_pkg;

    // byte address from execute
    typedef logic [`LSU_ADDR_W-1:0] addr_t;

    // one 64-bit word, load or store data
    typedef logic [`LSU_DATA_W-1:0] data_t;

    // access size in bits 1:0, unsigned load in bit 2
    typedef logic [2:0] funct3_t;

    // performance event count
    typedef logic [`LSU_CNT_W-1:0] cnt_t;

    // dcache controller states
    typedef enum logic [1:0] {
        C_IDLE,   // wait for request, then tag lookup
        C_REFILL, // burst read of a whole line
        C_WRITE,  // single beat store on the bus
        C_DONE    // answer the pipeline
    } cache_state_t;

endpackage

// ==== perf_counters.sv ====
`timescale 1ns/100ps

module perf_counters (
    input  logic          clk,
    input  logic          rst,
    input  logic          hit_pulse_i,  // one cycle per hit lookup
    input  logic          miss_pulse_i, // one cycle per miss lookup
    output lsu_pkg::cnt_t cache_hit_o,
    output lsu_pkg::cnt_t cache_miss_o
);

    lsu_pkg::cnt_t hit_cnt_q;
    lsu_pkg::cnt_t miss_cnt_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_cnt_q  <= '0;
            miss_cnt_q <= '0;
        end else begin
            if (hit_pulse_i)
                hit_cnt_q <= hit_cnt_q + 1'b1;
            if (miss_pulse_i)
                miss_cnt_q <= miss_cnt_q + 1'b1;
        end
    end

    assign cache_hit_o  = hit_cnt_q;
    assign cache_miss_o = miss_cnt_q;

endmodule

// ==== dcache.sv ====
`timescale 1ns/100ps
`include "lsu_macros.svh"

module dcache (
    input  logic             clk,
    input  logic             rst,
    // pipeline side
    input  logic             cpu_valid_i,   // level, held until cpu_ready_o
    input  logic             cpu_wen_i,
    input  lsu_pkg::addr_t   cpu_addr_i,
    input  lsu_pkg::data_t   cpu_wdata_i,
    input  lsu_pkg::funct3_t cpu_func3_i,
    output logic             cpu_ready_o,   // one cycle pulse
    output lsu_pkg::data_t   cpu_rdata_o,   // addressed word >> byte offset
    output logic             hit_pulse_o,
    output logic             miss_pulse_o,
    // burst read port
    input  logic             r_ready_i,
    input  logic             r_last_i,
    input  lsu_pkg::data_t   r_data_i,
    output logic             r_valid_o,
    output lsu_pkg::addr_t   r_addr_o,
    // single beat write port
    input  logic             w_ready_i,
    output logic             w_valid_o,
    output lsu_pkg::addr_t   w_addr_o,
    output lsu_pkg::data_t   w_data_o,
    output logic [1:0]       w_size_o
);

    localparam int WSEL_W = $clog2(`LSU_LINE_WORDS);
    localparam int OFF_W  = 3 + WSEL_W;                        // byte offset in line
    localparam int TAG_W  = `LSU_ADDR_W - `LSU_INDEX_W - OFF_W;
    localparam int LINES  = 1 << `LSU_INDEX_W;
    localparam int DEPTH  = LINES * `LSU_LINE_WORDS;
    localparam int BYTES  = `LSU_DATA_W / 8;

    lsu_pkg::cache_state_t state_q;

    // line storage
    lsu_pkg::data_t   data_mem [0:DEPTH-1];
    logic [TAG_W-1:0] tag_mem  [0:LINES-1];
    logic [LINES-1:0] valid_q;

    // latched request
    lsu_pkg::addr_t   req_addr_q;
    lsu_pkg::data_t   req_wdata_q;
    logic             req_wen_q;
    lsu_pkg::funct3_t req_func3_q;

    logic             lookup_q;  // request latched, compare this cycle
    logic             hit_q;     // lookup result kept for the store merge
    logic [WSEL_W-1:0] beat_q;   // refill word counter

    logic [2:0]              req_off;
    logic [WSEL_W-1:0]       req_word;
    logic [`LSU_INDEX_W-1:0] req_idx;
    logic [TAG_W-1:0]        req_tag;
    logic                    hit;
    lsu_pkg::data_t          line_word;
    lsu_pkg::data_t          lane_wdata;
    lsu_pkg::data_t          merged_word;
    logic [BYTES-1:0]        size_mask;
    logic [BYTES-1:0]        byte_mask;

    assign req_off  = req_addr_q[2:0];
    assign req_word = req_addr_q[OFF_W-1:3];
    assign req_idx  = req_addr_q[OFF_W+`LSU_INDEX_W-1:OFF_W];
    assign req_tag  = req_addr_q[`LSU_ADDR_W-1:OFF_W+`LSU_INDEX_W];

    assign hit       = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
    assign line_word = data_mem[{req_idx, req_word}];

    // store data moved into its byte lane
    assign lane_wdata = req_wdata_q << {req_off, 3'b000};

    always_comb begin
        case (req_func3_q[1:0])
            2'd0:    size_mask = 8'h01; // byte
            2'd1:    size_mask = 8'h03; // half
            2'd2:    size_mask = 8'h0f; // word
            default: size_mask = 8'hff; // double
        endcase
        byte_mask = size_mask << req_off;
        for (int b = 0; b < BYTES; b++) begin
            merged_word[b*8 +: 8] = byte_mask[b] ? lane_wdata[b*8 +: 8]
                                                 : line_word[b*8 +: 8];
        end
    end

    // request capture, only while idle and not already looking up
    always_ff @(posedge clk) begin
        if (state_q == lsu_pkg::C_IDLE && !lookup_q && cpu_valid_i) begin
            req_addr_q  <= cpu_addr_i;
            req_wdata_q <= cpu_wdata_i;
            req_wen_q   <= cpu_wen_i;
            req_func3_q <= cpu_func3_i;
        end
    end

    // line and tag arrays
    always_ff @(posedge clk) begin
        if (state_q == lsu_pkg::C_REFILL && r_ready_i) begin
            data_mem[{req_idx, beat_q}] <= r_data_i;   // beats arrive in word order
            if (r_last_i)
                tag_mem[req_idx] <= req_tag;
        end
        if (state_q == lsu_pkg::C_WRITE && w_ready_i && hit_q)
            data_mem[{req_idx, req_word}] <= merged_word; // write-through update
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= lsu_pkg::C_IDLE;
            lookup_q     <= 1'b0;
            hit_q        <= 1'b0;
            beat_q       <= '0;
            valid_q      <= '0;
            hit_pulse_o  <= 1'b0;
            miss_pulse_o <= 1'b0;
        end else begin
            hit_pulse_o  <= 1'b0;
            miss_pulse_o <= 1'b0;
            case (state_q)
                lsu_pkg::C_IDLE: begin
                    if (lookup_q) begin
                        lookup_q     <= 1'b0;
                        hit_q        <= hit;
                        hit_pulse_o  <= hit;
                        miss_pulse_o <= !hit;
                        if (req_wen_q) begin
                            state_q <= lsu_pkg::C_WRITE;   // no allocate on store miss
                        end else if (hit) begin
                            state_q <= lsu_pkg::C_DONE;
                        end else begin
                            state_q <= lsu_pkg::C_REFILL;
                            beat_q  <= '0;
                        end
                    end else if (cpu_valid_i) begin
                        lookup_q <= 1'b1;
                    end
                end
                lsu_pkg::C_REFILL: begin
                    if (r_ready_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (r_last_i) begin
                            valid_q[req_idx] <= 1'b1;
                            state_q          <= lsu_pkg::C_DONE;
                        end
                    end
                end
                lsu_pkg::C_WRITE: begin
                    if (w_ready_i)
                        state_q <= lsu_pkg::C_DONE;
                end
                default: begin
                    state_q <= lsu_pkg::C_IDLE; // C_DONE lasts one cycle
                end
            endcase
        end
    end

    assign cpu_ready_o = (state_q == lsu_pkg::C_DONE);
    assign cpu_rdata_o = line_word >> {req_off, 3'b000};

    assign r_valid_o = (state_q == lsu_pkg::C_REFILL);
    assign r_addr_o  = {req_tag, req_idx, {OFF_W{1'b0}}}; // line aligned

    assign w_valid_o = (state_q == lsu_pkg::C_WRITE);
    assign w_addr_o  = req_addr_q;
    assign w_data_o  = lane_wdata;
    assign w_size_o  = req_func3_q[1:0];

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/100ps
`include "lsu_macros.svh"

module mem_stage (
    input  logic             clk,
    input  logic             rst,
    // execute side
    input  lsu_pkg::addr_t   addr_i,
    input  lsu_pkg::data_t   wdata_i,
    input  logic             wen_i,
    input  lsu_pkg::funct3_t func3_i,
    input  logic             mem_valid_i,
    input  logic             ex_ready_i,
    output logic             mem_ready_o,
    output lsu_pkg::data_t   r_data_o,
    // read bus
    input  logic             r_ready_i,
    input  logic             r_last_i,
    input  lsu_pkg::data_t   r_data_i,
    output logic             r_valid_o,
    output lsu_pkg::addr_t   r_addr_o,
    // write bus
    input  logic             w_ready_i,
    output logic             w_valid_o,
    output lsu_pkg::addr_t   w_addr_o,
    output lsu_pkg::data_t   w_data_o,
    output logic [1:0]       w_size_o,
    // to the counters
    output logic             hit_pulse_o,
    output logic             miss_pulse_o
);

    logic           cpu_valid;
    logic           cpu_ready;
    lsu_pkg::data_t cpu_rdata;
    lsu_pkg::data_t load_ext;

    // no new cache request while the answer waits for execute
    assign cpu_valid = mem_valid_i & ~mem_ready_o;

    always_comb begin
        case (func3_i)
            3'd0: load_ext = {{(`LSU_DATA_W-8){cpu_rdata[7]}}, cpu_rdata[7:0]};    // lb
            3'd1: load_ext = {{(`LSU_DATA_W-16){cpu_rdata[15]}}, cpu_rdata[15:0]}; // lh
            3'd2: load_ext = {{(`LSU_DATA_W-32){cpu_rdata[31]}}, cpu_rdata[31:0]}; // lw
            3'd3: load_ext = cpu_rdata;                                            // ld
            3'd4: load_ext = {{(`LSU_DATA_W-8){1'b0}}, cpu_rdata[7:0]};            // lbu
            3'd5: load_ext = {{(`LSU_DATA_W-16){1'b0}}, cpu_rdata[15:0]};          // lhu
            3'd6: load_ext = {{(`LSU_DATA_W-32){1'b0}}, cpu_rdata[31:0]};          // lwu
            default: load_ext = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            mem_ready_o <= 1'b0;
        else if (mem_ready_o && ex_ready_i)
            mem_ready_o <= 1'b0;   // accepted by the next stage
        else if (cpu_ready)
            mem_ready_o <= 1'b1;
    end

    // load result held until accepted
    always_ff @(posedge clk) begin
        if (cpu_ready && !wen_i)
            r_data_o <= load_ext;
    end

    dcache u_dcache (
        .clk          (clk),
        .rst          (rst),
        .cpu_valid_i  (cpu_valid),
        .cpu_wen_i    (wen_i),
        .cpu_addr_i   (addr_i),
        .cpu_wdata_i  (wdata_i),
        .cpu_func3_i  (func3_i),
        .cpu_ready_o  (cpu_ready),
        .cpu_rdata_o  (cpu_rdata),
        .hit_pulse_o  (hit_pulse_o),
        .miss_pulse_o (miss_pulse_o),
        .r_ready_i    (r_ready_i),
        .r_last_i     (r_last_i),
        .r_data_i     (r_data_i),
        .r_valid_o    (r_valid_o),
        .r_addr_o     (r_addr_o),
        .w_ready_i    (w_ready_i),
        .w_valid_o    (w_valid_o),
        .w_addr_o     (w_addr_o),
        .w_data_o     (w_data_o),
        .w_size_o     (w_size_o)
    );

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/100ps

module lsu_top (
    input  logic             clk,
    input  logic             rst,
    // execute side
    input  lsu_pkg::addr_t   addr_i,
    input  lsu_pkg::data_t   wdata_i,
    input  logic             wen_i,
    input  lsu_pkg::funct3_t func3_i,
    input  logic             mem_valid_i,
    input  logic             ex_ready_i,
    output logic             mem_ready_o,
    output lsu_pkg::data_t   r_data_o,
    // performance counters
    output lsu_pkg::cnt_t    cache_hit_o,
    output lsu_pkg::cnt_t    cache_miss_o,
    // read bus
    input  logic             r_ready_i,
    input  logic             r_last_i,
    input  lsu_pkg::data_t   r_data_i,
    output logic             r_valid_o,
    output lsu_pkg::addr_t   r_addr_o,
    // write bus
    input  logic             w_ready_i,
    output logic             w_valid_o,
    output lsu_pkg::addr_t   w_addr_o,
    output lsu_pkg::data_t   w_data_o,
    output logic [1:0]       w_size_o
);

    logic hit_pulse;
    logic miss_pulse;

    mem_stage u_mem_stage (
        .clk          (clk),
        .rst          (rst),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .wen_i        (wen_i),
        .func3_i      (func3_i),
        .mem_valid_i  (mem_valid_i),
        .ex_ready_i   (ex_ready_i),
        .mem_ready_o  (mem_ready_o),
        .r_data_o     (r_data_o),
        .r_ready_i    (r_ready_i),
        .r_last_i     (r_last_i),
        .r_data_i     (r_data_i),
        .r_valid_o    (r_valid_o),
        .r_addr_o     (r_addr_o),
        .w_ready_i    (w_ready_i),
        .w_valid_o    (w_valid_o),
        .w_addr_o     (w_addr_o),
        .w_data_o     (w_data_o),
        .w_size_o     (w_size_o),
        .hit_pulse_o  (hit_pulse),
        .miss_pulse_o (miss_pulse)
    );

    perf_counters u_perf_counters (
        .clk          (clk),
        .rst          (rst),
        .hit_pulse_i  (hit_pulse),
        .miss_pulse_i (miss_pulse),
        .cache_hit_o  (cache_hit_o),
        .cache_miss_o (cache_miss_o)
    );

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_NS   = 4;  // 8 ns period
    localparam int RESET_CYC = 5;

    initial begin
        clk_o = 1'b0;
        forever #HALF_NS clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYC) @(posedge clk_o);
        #1 rst_o = 1'b0;  // released just after the edge
    end

endmodule

// ==== lsu_sva.sv ====
`timescale 1ns/100ps

module lsu_sva (
    input logic           clk,
    input logic           rst,
    input logic           mem_ready_i,
    input logic           ex_ready_i,
    input logic           r_valid_i,
    input logic           r_ready_i,
    input logic           r_last_i,
    input lsu_pkg::addr_t r_addr_i,
    input logic           w_valid_i,
    input logic           w_ready_i,
    input lsu_pkg::addr_t w_addr_i,
    input lsu_pkg::data_t w_data_i,
    input logic [1:0]     w_size_i
);

    a_ready_hold: assert property (@(posedge clk) disable iff (rst)
        mem_ready_i && !ex_ready_i |=> mem_ready_i)
        else $error("mem_ready_o fell before ex_ready_i");

    // burst request held until the last beat is taken
    a_read_hold: assert property (@(posedge clk) disable iff (rst)
        r_valid_i && !(r_ready_i && r_last_i) |=> r_valid_i && $stable(r_addr_i))
        else $error("r_valid_o or r_addr_o changed inside a burst");

    a_write_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_addr_i)
            && $stable(w_data_i) && $stable(w_size_i))
        else $error("write request changed before w_ready_i");

    a_bus_excl: assert property (@(posedge clk) disable iff (rst)
        !(r_valid_i && w_valid_i))
        else $error("read and write requests active together");

endmodule

// ==== lsu_tb.sv ====
`timescale 1ns/100ps
`include "lsu_macros.svh"

module lsu_tb;

    localparam int NUM_REQ     = 400;
    localparam int CYCLE_BOUND = 40;   // cycles allowed per request
    localparam int CLK_NS      = 8;
    localparam int WATCHDOG_NS = (NUM_REQ * CYCLE_BOUND + 30) * CLK_NS;
    localparam int WIN_W       = 14;   // 16 KB window
    localparam int MEM_WORDS   = 1 << (WIN_W - 3);
    localparam int LINES       = 1 << `LSU_INDEX_W;
    localparam int OFF_W       = 3 + $clog2(`LSU_LINE_WORDS);
    localparam logic [31:0] WIN_BASE = 32'h8000_0000;

    logic             clk;
    logic             rst;
    lsu_pkg::addr_t   addr_i;
    lsu_pkg::data_t   wdata_i;
    logic             wen_i;
    lsu_pkg::funct3_t func3_i;
    logic             mem_valid_i;
    logic             ex_ready_i;
    logic             mem_ready_o;
    lsu_pkg::data_t   r_data_o;
    lsu_pkg::cnt_t    cache_hit_o;
    lsu_pkg::cnt_t    cache_miss_o;
    logic             r_ready_i;
    logic             r_last_i;
    lsu_pkg::data_t   r_data_i;
    logic             r_valid_o;
    lsu_pkg::addr_t   r_addr_o;
    logic             w_ready_i;
    logic             w_valid_o;
    lsu_pkg::addr_t   w_addr_o;
    lsu_pkg::data_t   w_data_o;
    logic [1:0]       w_size_o;

    lsu_pkg::data_t bus_mem    [0:MEM_WORDS-1];  // memory behind the bus
    lsu_pkg::data_t model_mem  [0:MEM_WORDS-1];  // reference view updated per request
    lsu_pkg::addr_t model_line [0:LINES-1];
    logic           model_valid[0:LINES-1];
    logic [31:0]    lfsr_q;
    int             rd_beat;
    int             bursts;
    int             writes;
    lsu_pkg::addr_t exp_line;   // all ones when no burst is expected
    lsu_pkg::addr_t exp_waddr;  // all ones when no write is expected
    lsu_pkg::data_t exp_wdata;
    logic [1:0]     exp_wsize;
    lsu_pkg::cnt_t  exp_hits;
    lsu_pkg::cnt_t  exp_misses;
    logic           last_store; // previous request was a store
    lsu_pkg::addr_t last_addr;
    logic [1:0]     last_size;

    tb_clkgen u_clkgen (
        .clk_o (clk),
        .rst_o (rst)
    );

    lsu_top DUT (
        .clk          (clk),
        .rst          (rst),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .wen_i        (wen_i),
        .func3_i      (func3_i),
        .mem_valid_i  (mem_valid_i),
        .ex_ready_i   (ex_ready_i),
        .mem_ready_o  (mem_ready_o),
        .r_data_o     (r_data_o),
        .cache_hit_o  (cache_hit_o),
        .cache_miss_o (cache_miss_o),
        .r_ready_i    (r_ready_i),
        .r_last_i     (r_last_i),
        .r_data_i     (r_data_i),
        .r_valid_o    (r_valid_o),
        .r_addr_o     (r_addr_o),
        .w_ready_i    (w_ready_i),
        .w_valid_o    (w_valid_o),
        .w_addr_o     (w_addr_o),
        .w_data_o     (w_data_o),
        .w_size_o     (w_size_o)
    );

    bind lsu_top lsu_sva u_lsu_sva (
        .clk         (clk),
        .rst         (rst),
        .mem_ready_i (mem_ready_o),
        .ex_ready_i  (ex_ready_i),
        .r_valid_i   (r_valid_o),
        .r_ready_i   (r_ready_i),
        .r_last_i    (r_last_i),
        .r_addr_i    (r_addr_o),
        .w_valid_i   (w_valid_o),
        .w_ready_i   (w_ready_i),
        .w_addr_i    (w_addr_o),
        .w_data_i    (w_data_o),
        .w_size_i    (w_size_o)
    );

    // taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic lsu_pkg::data_t fill_word(input int idx);
        logic [31:0] a;
        a = WIN_BASE + 32'(idx * 8);
        return {a * 32'h9E37_79B1, a ^ 32'hC3A5_5A3C};
    endfunction

    function automatic int word_of(input lsu_pkg::addr_t a);
        return int'(a[WIN_W-1:3]);
    endfunction

    // keep the low access bytes and sign fill unless bit 2 is set
    function automatic lsu_pkg::data_t extend_load(input lsu_pkg::data_t raw,
                                                   input lsu_pkg::funct3_t f);
        int             nbits;
        lsu_pkg::data_t mask;
        if (f == 3'd7)
            return '0;
        nbits = 8 << f[1:0];
        mask  = (nbits == 64) ? '1 : ((64'd1 << nbits) - 64'd1);
        if (!f[2] && raw[nbits-1])
            return raw | ~mask;
        return raw & mask;
    endfunction

    task automatic stop_failed();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t %s got %h expected %h", $time, name, actual, expected);
            stop_failed();
        end
    endtask

    // called at the falling edge to look at handshakes due on the next rising edge
    task automatic sample_bus();
        int w;
        int off;
        int nb;
        if (r_valid_o && r_ready_i) begin
            check_value("r_addr_o", 64'(r_addr_o), 64'(exp_line));
            if (rd_beat == `LSU_LINE_WORDS - 1) begin
                rd_beat = 0;
                bursts++;
            end else begin
                rd_beat++;
            end
        end
        if (w_valid_o && w_ready_i) begin
            check_value("w_addr_o", 64'(w_addr_o), 64'(exp_waddr));
            check_value("w_data_o", w_data_o, exp_wdata);
            check_value("w_size_o", 64'(w_size_o), 64'(exp_wsize));
            w   = word_of(w_addr_o);
            off = int'(w_addr_o[2:0]);
            nb  = 1 << w_size_o;
            for (int b = off; b < off + nb; b++)
                bus_mem[w][b*8 +: 8] = w_data_o[b*8 +: 8];
            writes++;
        end
    endtask

    task automatic drive_bus();
        r_ready_i  = (rand_bits(2) != 0);  // about three in four cycles
        w_ready_i  = (rand_bits(2) != 0);
        ex_ready_i = (rand_bits(2) != 0);
        if (r_valid_o) begin
            r_data_i = bus_mem[(word_of(r_addr_o) + rd_beat) % MEM_WORDS];
            r_last_i = (rd_beat == `LSU_LINE_WORDS - 1);
        end else begin
            r_data_i = '0;
            r_last_i = 1'b0;
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        sample_bus();
        @(posedge clk);
        #1;
        drive_bus();
    endtask

    task automatic run_request();
        logic [63:0]      r;
        lsu_pkg::addr_t   a;
        lsu_pkg::funct3_t f;
        logic             we;
        logic             reuse;
        lsu_pkg::data_t   wd;
        lsu_pkg::data_t   exp_rdata;
        lsu_pkg::data_t   held_rdata;
        lsu_pkg::addr_t   line;
        int               w;
        int               off;
        int               idx;
        int               nb;
        logic             hit;
        logic             held;
        logic             done;

        reuse = last_store && (rand_bits(1) == 64'd1);
        we    = reuse ? 1'b0 : (rand_bits(2) == 0);
        r  = rand_bits(3);
        f  = r[2:0];
        if (we)
            f[2] = 1'b0;  // sb, sh, sw, sd
        if (reuse)
            f = {f[2] & ~(&last_size), last_size};  // same size as the store and not code 7
        nb = 1 << f[1:0];
        r  = rand_bits(WIN_W);
        a  = WIN_BASE | (32'(r[WIN_W-1:0]) & ~32'(nb - 1));
        if (reuse)
            a = last_addr;  // read back the bytes just stored
        wd = we ? rand_bits(64) : '0;
        last_store = we;
        last_addr  = a;
        last_size  = f[1:0];

        w    = word_of(a);
        off  = int'(a[2:0]);
        idx  = int'(a[OFF_W +: `LSU_INDEX_W]);
        line = a & ~32'((1 << OFF_W) - 1);
        hit  = model_valid[idx] && (model_line[idx] == line);
        if (hit)
            exp_hits = exp_hits + 64'd1;
        else
            exp_misses = exp_misses + 64'd1;

        exp_line  = '1;
        exp_waddr = '1;
        exp_rdata = '0;
        if (we) begin
            exp_waddr = a;
            exp_wdata = wd << (off * 8);
            exp_wsize = f[1:0];
            for (int b = 0; b < nb; b++)
                model_mem[w][(off + b)*8 +: 8] = wd[b*8 +: 8];
        end else begin
            exp_rdata = extend_load(model_mem[w] >> (off * 8), f);
            if (!hit) begin  // only loads allocate
                exp_line         = line;
                model_valid[idx] = 1'b1;
                model_line[idx]  = line;
            end
        end

        addr_i      = a;
        wdata_i     = wd;
        wen_i       = we;
        func3_i     = f;
        mem_valid_i = 1'b1;
        bursts      = 0;
        writes      = 0;
        held        = 1'b0;
        done        = 1'b0;
        held_rdata  = '0;
        while (!done) begin
            @(negedge clk);
            sample_bus();
            if (mem_ready_o) begin
                if (!held) begin
                    held       = 1'b1;
                    held_rdata = r_data_o;
                    check_value("bursts", 64'(bursts), (!we && !hit) ? 64'd1 : 64'd0);
                    check_value("writes", 64'(writes), we ? 64'd1 : 64'd0);
                    check_value("cache_hit_o", cache_hit_o, exp_hits);
                    check_value("cache_miss_o", cache_miss_o, exp_misses);
                    if (!we)
                        check_value("r_data_o", r_data_o, exp_rdata);
                end else begin
                    check_value("r_data_o", r_data_o, held_rdata);
                end
                check_value("r_valid_o", 64'(r_valid_o), 64'd0);  // cache idle while held
                check_value("w_valid_o", 64'(w_valid_o), 64'd0);
                done = ex_ready_i;
            end else if (held) begin
                $display("mem_ready_o dropped before execute accepted the result");
                stop_failed();
            end
            @(posedge clk);
            #1;
            drive_bus();
        end
        mem_valid_i = 1'b0;
        exp_line    = '1;
        exp_waddr   = '1;
        check_value("mem_ready_o", 64'(mem_ready_o), 64'd0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a request never completed", WATCHDOG_NS);
        stop_failed();
    end

    initial begin
        lfsr_q      = 32'd94;
        addr_i      = '0;
        wdata_i     = '0;
        wen_i       = 1'b0;
        func3_i     = '0;
        mem_valid_i = 1'b0;
        ex_ready_i  = 1'b0;
        r_ready_i   = 1'b0;
        r_last_i    = 1'b0;
        r_data_i    = '0;
        w_ready_i   = 1'b0;
        rd_beat     = 0;
        bursts      = 0;
        writes      = 0;
        exp_line    = '1;
        exp_waddr   = '1;
        exp_wdata   = '0;
        exp_wsize   = '0;
        exp_hits    = '0;
        exp_misses  = '0;
        last_store  = 1'b0;
        last_addr   = '0;
        last_size   = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            bus_mem[i]   = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        for (int i = 0; i < LINES; i++) begin
            model_valid[i] = 1'b0;
            model_line[i]  = '0;
        end

        wait (rst === 1'b0);
        @(posedge clk);
        #1;
        check_value("mem_ready_o", 64'(mem_ready_o), 64'd0);
        check_value("r_valid_o", 64'(r_valid_o), 64'd0);
        check_value("w_valid_o", 64'(w_valid_o), 64'd0);
        check_value("cache_hit_o", cache_hit_o, 64'd0);
        check_value("cache_miss_o", cache_miss_o, 64'd0);

        for (int n = 0; n < NUM_REQ; n++) begin
            run_request();
            if (rand_bits(2) == 0)
                idle_cycle();  // sometimes a bubble from execute
        end

        check_value("cache_hit_o", cache_hit_o, exp_hits);
        check_value("cache_miss_o", cache_miss_o, exp_misses);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
lsu_pkg.sv
perf_counters.sv
dcache.sv
mem_stage.sv
lsu_top.sv
tb_clkgen.sv
lsu_sva.sv
lsu_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := lsu_tb
FILELIST := vlog.f

SOURCES  := $(shell grep -v '^+' $(FILELIST)) lsu_macros.svh
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
